/* aluPkg.sv */
package aluPkg;

	// Default operand width, overridden from the top level
	localparam int defaultDataWidth = 16;

	// Opcode map for the execute unit
	// Bit 3 low selects the arithmetic group
	// Arithmetic codes keep the adder encoding
	// Bits 2:1 pick the second adder operand, bit 0 is the carry-in
	// Code 4'h7 is unused and treated as LD
	// Bits 3:2 equal to 2'b10 select the logic group
	// Bits 1:0 then pick AND, OR, XOR, NOT
	// Bits 3:1 equal to 3'b110 select the one-bit shifter
	// Bit 0 picks the direction, 0 left and 1 right
	// Codes 4'hE and 4'hF are unused and treated as LD
	typedef enum logic [3:0] {
		// Transfer A
		LD  = 4'h0,
		// A + 1
		INC = 4'h1,
		// A + B
		ADD = 4'h2,
		// A + B + 1
		ADC = 4'h3,
		// A + ~B, subtract with borrow
		SBB = 4'h4,
		// A + ~B + 1, true subtraction
		SUB = 4'h5,
		// A + all ones, decrement
		DEC = 4'h6,
		// Logic group
		AND = 4'h8,
		OR  = 4'h9,
		XOR = 4'hA,
		NOT = 4'hB,
		// Shift group, vacated bit is filled with zero
		LSH = 4'hC,
		RSH = 4'hD
	} aluOp;

	// Command port handshake FSM
	// IDLE waits for a client command
	// REQUEST holds aluReq until the arbiter acknowledges
	// DONE presents the result with cmdAck high
	// RELEASE waits for the arbiter acknowledge to fall
	typedef enum logic [1:0] {
		IDLE,
		REQUEST,
		DONE,
		RELEASE
	} portState;

endpackage

/* aluCore.sv */
`timescale 1ns/1ps

module aluCore #(
	parameter int dataWidth = aluPkg::defaultDataWidth
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 issue,
	input  aluPkg::aluOp         issueOp,
	input  logic [dataWidth-1:0] issueA,
	input  logic [dataWidth-1:0] issueB,
	output logic                 resultValid,
	output logic [dataWidth-1:0] result,
	output logic                 carry,
	output logic                 zero
);

	// Second adder operand and carry-in
	logic [dataWidth-1:0] addOperand;
	logic                 addCarryIn;
	// One extra bit keeps the carry out
	logic [dataWidth:0]   addSum;
	// Combinational result ahead of the output register
	logic [dataWidth-1:0] nextResult;
	logic                 nextCarry;

	// Operand select for the shared adder
	// Zero, B, inverted B or all ones
	always_comb begin
		addOperand = '0;
		addCarryIn = 1'b0;
		case (issueOp)
			aluPkg::INC: begin
				addCarryIn = 1'b1;
			end
			aluPkg::ADD: begin
				addOperand = issueB;
			end
			aluPkg::ADC: begin
				addOperand = issueB;
				addCarryIn = 1'b1;
			end
			aluPkg::SBB: begin
				addOperand = ~issueB;
			end
			aluPkg::SUB: begin
				addOperand = ~issueB;
				addCarryIn = 1'b1;
			end
			aluPkg::DEC: begin
				addOperand = '1;
			end
			// LD and the unused codes add nothing
			default: begin
				addOperand = '0;
				addCarryIn = 1'b0;
			end
		endcase
	end

	// Single adder shared by every arithmetic opcode
	assign addSum = {1'b0, issueA} + {1'b0, addOperand} + {{dataWidth{1'b0}}, addCarryIn};

	// Result and carry select per function group
	always_comb begin
		nextResult = addSum[dataWidth-1:0];
		nextCarry  = addSum[dataWidth];
		case (issueOp)
			// Logic group clears carry
			aluPkg::AND: begin
				nextResult = issueA & issueB;
				nextCarry  = 1'b0;
			end
			aluPkg::OR: begin
				nextResult = issueA | issueB;
				nextCarry  = 1'b0;
			end
			aluPkg::XOR: begin
				nextResult = issueA ^ issueB;
				nextCarry  = 1'b0;
			end
			aluPkg::NOT: begin
				nextResult = ~issueA;
				nextCarry  = 1'b0;
			end
			// Bit shifted out lands in carry
			aluPkg::LSH: begin
				nextResult = {issueA[dataWidth-2:0], 1'b0};
				nextCarry  = issueA[dataWidth-1];
			end
			aluPkg::RSH: begin
				nextResult = {1'b0, issueA[dataWidth-1:1]};
				nextCarry  = issueA[0];
			end
			// Arithmetic, LD and unused codes take the adder output
			default: begin
				nextResult = addSum[dataWidth-1:0];
				nextCarry  = addSum[dataWidth];
			end
		endcase
	end

	// Valid follows issue by exactly one cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= issue;
		end
	end

	// Result and flags are only loaded on issue
	// Held until the next issue
	always_ff @(posedge clk) begin
		if (issue) begin
			result <= nextResult;
			carry  <= nextCarry;
			zero   <= (nextResult == '0);
		end
	end

endmodule

/* aluArbiter.sv */
`timescale 1ns/1ps

module aluArbiter #(
	parameter int dataWidth = aluPkg::defaultDataWidth
) (
	input  logic                 clk,
	input  logic                 rst,
	// Port 0 request side
	input  logic                 req0,
	input  aluPkg::aluOp         op0,
	input  logic [dataWidth-1:0] a0,
	input  logic [dataWidth-1:0] b0,
	// Port 1 request side
	input  logic                 req1,
	input  aluPkg::aluOp         op1,
	input  logic [dataWidth-1:0] a1,
	input  logic [dataWidth-1:0] b1,
	// Core result
	input  logic                 resultValid,
	input  logic [dataWidth-1:0] result,
	input  logic                 carry,
	input  logic                 zero,
	// Acknowledges and shared result bus
	output logic                 ack0,
	output logic                 ack1,
	output logic [dataWidth-1:0] aluResult,
	output logic                 aluCarry,
	output logic                 aluZero,
	// Core issue side
	output logic                 issue,
	output aluPkg::aluOp         issueOp,
	output logic [dataWidth-1:0] issueA,
	output logic [dataWidth-1:0] issueB
);

	// FREE accepts a request, EXEC waits on the core
	// HOLD keeps the acknowledge up until the request falls
	typedef enum logic [1:0] {
		FREE,
		EXEC,
		HOLD
	} arbState;

	arbState state;
	// Granted port index
	logic    grant;
	// Port that wins a tie
	logic    priorityPort;
	logic    nextGrant;
	// Request line of the port that owns the core
	logic    grantReq;

	assign grantReq = grant ? req1 : req0;

	// Round-robin pick, ties go to the priority port
	always_comb begin
		if (req0 && req1) begin
			nextGrant = priorityPort;
		end else begin
			nextGrant = req1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= FREE;
			grant        <= 1'b0;
			priorityPort <= 1'b0;
			issue        <= 1'b0;
		end else begin
			// Issue is a single-cycle pulse
			issue <= 1'b0;
			case (state)
				FREE: begin
					if (req0 || req1) begin
						grant <= nextGrant;
						issue <= 1'b1;
						state <= EXEC;
					end
				end
				EXEC: begin
					if (resultValid) begin
						state <= HOLD;
					end
				end
				HOLD: begin
					// Release done, hand priority to the other port
					if (!grantReq) begin
						priorityPort <= ~grant;
						state        <= FREE;
					end
				end
				default: begin
					state <= FREE;
				end
			endcase
		end
	end

	// Ports hold their operands while requesting
	assign issueOp = grant ? op1 : op0;
	assign issueA  = grant ? a1 : a0;
	assign issueB  = grant ? b1 : b0;

	// Capture the core output for the shared bus
	always_ff @(posedge clk) begin
		if ((state == EXEC) && resultValid) begin
			aluResult <= result;
			aluCarry  <= carry;
			aluZero   <= zero;
		end
	end

	// Acknowledge only toward the granted port
	assign ack0 = (state == HOLD) && !grant;
	assign ack1 = (state == HOLD) && grant;

endmodule

/* cmdPort.sv */
`timescale 1ns/1ps

module cmdPort #(
	parameter int dataWidth = aluPkg::defaultDataWidth
) (
	input  logic                 clk,
	input  logic                 rst,
	// Client command
	input  logic                 cmdReq,
	input  aluPkg::aluOp         cmdOp,
	input  logic [dataWidth-1:0] cmdA,
	input  logic [dataWidth-1:0] cmdB,
	// Arbiter acknowledge and shared result bus
	input  logic                 aluAck,
	input  logic [dataWidth-1:0] aluResult,
	input  logic                 aluCarry,
	input  logic                 aluZero,
	// Client response
	output logic                 cmdAck,
	output logic [dataWidth-1:0] cmdResult,
	output logic                 cmdCarry,
	output logic                 cmdZero,
	// Request toward the arbiter
	output logic                 aluReq,
	output aluPkg::aluOp         aluOp,
	output logic [dataWidth-1:0] aluA,
	output logic [dataWidth-1:0] aluB
);

	aluPkg::portState state;

	// Command accepted in this cycle
	logic accept;
	// Shared bus belongs to this port in this cycle
	logic capture;

	assign accept  = (state == aluPkg::IDLE) && cmdReq;
	assign capture = (state == aluPkg::REQUEST) && aluAck;

	// Four-phase on both sides
	// Client side: cmdReq up, cmdAck up, cmdReq down, cmdAck down
	// Arbiter side runs the same sequence nested inside
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= aluPkg::IDLE;
		end else begin
			case (state)
				aluPkg::IDLE: begin
					if (cmdReq) begin
						state <= aluPkg::REQUEST;
					end
				end
				aluPkg::REQUEST: begin
					// aluReq falls as soon as the result is taken
					if (aluAck) begin
						state <= aluPkg::DONE;
					end
				end
				aluPkg::DONE: begin
					// A client holding cmdReq stalls here
					// The arbiter is already free for the other port
					if (!cmdReq) begin
						state <= aluPkg::RELEASE;
					end
				end
				aluPkg::RELEASE: begin
					// No new request until the arbiter side is idle
					if (!aluAck) begin
						state <= aluPkg::IDLE;
					end
				end
				default: begin
					state <= aluPkg::IDLE;
				end
			endcase
		end
	end

	// Command copy, stable for the whole arbiter handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			aluOp <= cmdOp;
			aluA  <= cmdA;
			aluB  <= cmdB;
		end
	end

	// Result copy, stable while cmdAck is high
	always_ff @(posedge clk) begin
		if (capture) begin
			cmdResult <= aluResult;
			cmdCarry  <= aluCarry;
			cmdZero   <= aluZero;
		end
	end

	assign aluReq = (state == aluPkg::REQUEST);
	assign cmdAck = (state == aluPkg::DONE);

endmodule

/* aluTop.sv */
`timescale 1ns/1ps

module aluTop #(
	parameter int dataWidth = aluPkg::defaultDataWidth
) (
	input  logic                 clk,
	input  logic                 rst,
	// Client 0
	input  logic                 cmdReq0,
	input  aluPkg::aluOp         cmdOp0,
	input  logic [dataWidth-1:0] cmdA0,
	input  logic [dataWidth-1:0] cmdB0,
	output logic                 cmdAck0,
	output logic [dataWidth-1:0] cmdResult0,
	output logic                 cmdCarry0,
	output logic                 cmdZero0,
	// Client 1
	input  logic                 cmdReq1,
	input  aluPkg::aluOp         cmdOp1,
	input  logic [dataWidth-1:0] cmdA1,
	input  logic [dataWidth-1:0] cmdB1,
	output logic                 cmdAck1,
	output logic [dataWidth-1:0] cmdResult1,
	output logic                 cmdCarry1,
	output logic                 cmdZero1
);

	// Port to arbiter links
	logic                 aluReq0;
	logic                 aluReq1;
	aluPkg::aluOp         aluOp0;
	aluPkg::aluOp         aluOp1;
	logic [dataWidth-1:0] aluA0;
	logic [dataWidth-1:0] aluA1;
	logic [dataWidth-1:0] aluB0;
	logic [dataWidth-1:0] aluB1;
	logic                 aluAck0;
	logic                 aluAck1;
	// Result bus shared by both ports
	logic [dataWidth-1:0] aluResult;
	logic                 aluCarry;
	logic                 aluZero;
	// Arbiter to core
	logic                 issue;
	aluPkg::aluOp         issueOp;
	logic [dataWidth-1:0] issueA;
	logic [dataWidth-1:0] issueB;
	logic                 resultValid;
	logic [dataWidth-1:0] result;
	logic                 carry;
	logic                 zero;

	cmdPort #(.dataWidth(dataWidth)) i_cmdPort0 (
		.clk(clk), .rst(rst),
		.cmdReq(cmdReq0), .cmdOp(cmdOp0), .cmdA(cmdA0), .cmdB(cmdB0),
		.aluAck(aluAck0), .aluResult(aluResult), .aluCarry(aluCarry), .aluZero(aluZero),
		.cmdAck(cmdAck0), .cmdResult(cmdResult0), .cmdCarry(cmdCarry0), .cmdZero(cmdZero0),
		.aluReq(aluReq0), .aluOp(aluOp0), .aluA(aluA0), .aluB(aluB0)
	);

	cmdPort #(.dataWidth(dataWidth)) i_cmdPort1 (
		.clk(clk), .rst(rst),
		.cmdReq(cmdReq1), .cmdOp(cmdOp1), .cmdA(cmdA1), .cmdB(cmdB1),
		.aluAck(aluAck1), .aluResult(aluResult), .aluCarry(aluCarry), .aluZero(aluZero),
		.cmdAck(cmdAck1), .cmdResult(cmdResult1), .cmdCarry(cmdCarry1), .cmdZero(cmdZero1),
		.aluReq(aluReq1), .aluOp(aluOp1), .aluA(aluA1), .aluB(aluB1)
	);

	// Round-robin access to the single core
	aluArbiter #(.dataWidth(dataWidth)) i_aluArbiter (
		.clk(clk), .rst(rst),
		.req0(aluReq0), .op0(aluOp0), .a0(aluA0), .b0(aluB0),
		.req1(aluReq1), .op1(aluOp1), .a1(aluA1), .b1(aluB1),
		.resultValid(resultValid), .result(result), .carry(carry), .zero(zero),
		.ack0(aluAck0), .ack1(aluAck1),
		.aluResult(aluResult), .aluCarry(aluCarry), .aluZero(aluZero),
		.issue(issue), .issueOp(issueOp), .issueA(issueA), .issueB(issueB)
	);

	aluCore #(.dataWidth(dataWidth)) i_aluCore (
		.clk(clk), .rst(rst),
		.issue(issue), .issueOp(issueOp), .issueA(issueA), .issueB(issueB),
		.resultValid(resultValid), .result(result), .carry(carry), .zero(zero)
	);

endmodule

/* aluArbiter_asserts.sv */
`timescale 1ns/1ps

module aluArbiter_asserts (
	input logic clk,
	input logic rst,
	input logic req0,
	input logic req1,
	input logic ack0,
	input logic ack1,
	input logic issue
);

	// Only the granted port sees an acknowledge
	oneAck: assert property (@(posedge clk) disable iff (rst) !(ack0 && ack1))
		else $error("ack0 and ack1 are high together");

	// Acknowledge answers a live request
	ackNeedsReq0: assert property (@(posedge clk) disable iff (rst) $rose(ack0) |-> req0)
		else $error("ack0 rose without req0");

	ackNeedsReq1: assert property (@(posedge clk) disable iff (rst) $rose(ack1) |-> req1)
		else $error("ack1 rose without req1");

	// Core is never started during a release
	issueQuiet: assert property (@(posedge clk) disable iff (rst) issue |-> !ack0 && !ack1)
		else $error("issue pulsed while an acknowledge was high");

endmodule

bind aluArbiter aluArbiter_asserts i_aluArbiterAsserts (
	.clk(clk),
	.rst(rst),
	.req0(req0),
	.req1(req1),
	.ack0(ack0),
	.ack1(ack1),
	.issue(issue)
);

/* aluTopTb.sv */
`timescale 1ns/1ps

module aluTopTb;

	localparam int dataWidth = aluPkg::defaultDataWidth;
	localparam int clkPeriod = 4;
	// Sum of 256, 5, 2, 400 and 2 transactions over the five tests
	localparam int numTransactions = 665;
	localparam int cyclesPerTransaction = 40;

	logic                 clk;
	logic                 rst;
	logic                 cmdReq0;
	aluPkg::aluOp         cmdOp0;
	logic [dataWidth-1:0] cmdA0;
	logic [dataWidth-1:0] cmdB0;
	logic                 cmdAck0;
	logic [dataWidth-1:0] cmdResult0;
	logic                 cmdCarry0;
	logic                 cmdZero0;
	logic                 cmdReq1;
	aluPkg::aluOp         cmdOp1;
	logic [dataWidth-1:0] cmdA1;
	logic [dataWidth-1:0] cmdB1;
	logic                 cmdAck1;
	logic [dataWidth-1:0] cmdResult1;
	logic                 cmdCarry1;
	logic                 cmdZero1;

	// Port index of each client acknowledge, in arrival order
	int ackOrder[$];

	aluTop #(.dataWidth(dataWidth)) i_aluTop (.*);

	always #(clkPeriod / 2) clk = ~clk;

	// Expected {carry, result} from the opcode table
	function automatic logic [dataWidth:0] modelAlu(input aluPkg::aluOp op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b);
		logic [dataWidth:0] wideA;
		logic [dataWidth:0] wideB;
		logic [dataWidth:0] one;
		wideA = {1'b0, a};
		wideB = {1'b0, b};
		one = {{dataWidth{1'b0}}, 1'b1};
		case (op)
			aluPkg::INC: return wideA + one;
			aluPkg::ADD: return wideA + wideB;
			aluPkg::ADC: return wideA + wideB + one;
			// Carry low means a borrow happened
			aluPkg::SBB: return wideA + {1'b0, ~b};
			aluPkg::SUB: return wideA + {1'b0, ~b} + one;
			aluPkg::DEC: return wideA + {1'b0, {dataWidth{1'b1}}};
			aluPkg::AND: return {1'b0, a & b};
			aluPkg::OR:  return {1'b0, a | b};
			aluPkg::XOR: return {1'b0, a ^ b};
			aluPkg::NOT: return {1'b0, ~a};
			// Shifted-out bit becomes the carry
			aluPkg::LSH: return {a, 1'b0};
			aluPkg::RSH: return {a[0], 1'b0, a[dataWidth-1:1]};
			// LD and the unused codes pass A through
			default: return wideA;
		endcase
	endfunction

	function automatic logic ackOf(input int port);
		return (port == 0) ? cmdAck0 : cmdAck1;
	endfunction

	function automatic logic [dataWidth-1:0] randWord();
		logic [31:0] r;
		r = $urandom();
		return r[dataWidth-1:0];
	endfunction

	task automatic checkResult(input logic [dataWidth-1:0] got,
			input logic [dataWidth-1:0] exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic checkFlag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic checkOrder(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("[ERROR] %0t: %s acknowledged port %0d first, expected port %0d",
				$time, what, got, exp);
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic checkState(input aluPkg::portState got, input aluPkg::portState exp,
			input string what);
		if (got !== exp) begin
			$display("[ERROR] %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
			$display("Simulation failed");
			$fatal(1);
		end
	endtask

	task automatic applyReset();
		@(posedge clk);
		rst <= 1'b1;
		cmdReq0 <= 1'b0;
		cmdReq1 <= 1'b0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	endtask

	// One full client handshake with hold extra cycles of cmdReq after cmdAck
	task automatic runAndCheck(input int port, input aluPkg::aluOp op,
			input logic [dataWidth-1:0] a, input logic [dataWidth-1:0] b, input int hold);
		logic [dataWidth:0]   expected;
		logic [dataWidth-1:0] gotResult;
		logic                 gotCarry;
		logic                 gotZero;
		string                what;
		int                   cycles;
		expected = modelAlu(op, a, b);
		what = $sformatf("port %0d op %0h", port, op);
		@(posedge clk);
		if (port == 0) begin
			cmdOp0 <= op;
			cmdA0 <= a;
			cmdB0 <= b;
			cmdReq0 <= 1'b1;
		end else begin
			cmdOp1 <= op;
			cmdA1 <= a;
			cmdB1 <= b;
			cmdReq1 <= 1'b1;
		end
		// Outputs are read on the falling edge
		do @(negedge clk); while (!ackOf(port));
		ackOrder.push_back(port);
		gotResult = (port == 0) ? cmdResult0 : cmdResult1;
		gotCarry = (port == 0) ? cmdCarry0 : cmdCarry1;
		gotZero = (port == 0) ? cmdZero0 : cmdZero1;
		checkResult(gotResult, expected[dataWidth-1:0], {what, " result"});
		checkFlag(gotCarry, expected[dataWidth], {what, " carry"});
		checkFlag(gotZero, expected[dataWidth-1:0] == '0, {what, " zero"});
		for (cycles = 0; cycles < hold; cycles++) begin
			@(negedge clk);
			checkFlag(ackOf(port), 1'b1, {what, " held cmdAck"});
			checkResult((port == 0) ? cmdResult0 : cmdResult1, expected[dataWidth-1:0],
				{what, " held result"});
			checkFlag((port == 0) ? cmdCarry0 : cmdCarry1, expected[dataWidth],
				{what, " held carry"});
			checkFlag((port == 0) ? cmdZero0 : cmdZero1, expected[dataWidth-1:0] == '0,
				{what, " held zero"});
		end
		@(posedge clk);
		if (port == 0) begin
			cmdReq0 <= 1'b0;
		end else begin
			cmdReq1 <= 1'b0;
		end
		do @(negedge clk); while (ackOf(port));
	endtask

	// Every code including the unused ones against edge operands
	task automatic sweepOpcodes();
		logic [dataWidth-1:0] edgeVals [4];
		int op;
		int ia;
		int ib;
		edgeVals[0] = '0;
		edgeVals[1] = '1;
		edgeVals[2] = {1'b1, {(dataWidth-1){1'b0}}};
		edgeVals[3] = {{(dataWidth-1){1'b0}}, 1'b1};
		for (op = 0; op < 16; op++) begin
			for (ia = 0; ia < 4; ia++) begin
				for (ib = 0; ib < 4; ib++) begin
					runAndCheck(0, aluPkg::aluOp'(op[3:0]), edgeVals[ia], edgeVals[ib], 0);
				end
			end
		end
	endtask

	task automatic contendBothPorts();
		applyReset();
		ackOrder.delete();
		fork
			runAndCheck(0, aluPkg::ADD, 16'h1234, 16'h4321, 0);
			runAndCheck(1, aluPkg::SUB, 16'h0100, 16'h0200, 0);
		join
		checkOrder(ackOrder[0], 0, "first pair");
		// Lone port 0 grant hands priority to port 1
		runAndCheck(0, aluPkg::INC, 16'hFFFF, 16'h0000, 0);
		ackOrder.delete();
		fork
			runAndCheck(0, aluPkg::ADC, 16'h7FFF, 16'h0000, 0);
			runAndCheck(1, aluPkg::SBB, 16'h0005, 16'h0003, 0);
		join
		checkOrder(ackOrder[0], 1, "second pair");
	endtask

	task automatic stallPortZero();
		fork
			runAndCheck(0, aluPkg::XOR, 16'hA5A5, 16'h0FF0, 20);
			begin
				do @(negedge clk); while (!cmdAck0);
				runAndCheck(1, aluPkg::DEC, 16'h0000, 16'h0000, 0);
				checkFlag(cmdAck0, 1'b1, "stalled port 0 cmdAck");
			end
		join
	endtask

	task automatic randomStream(input int port);
		logic [31:0] r;
		int n;
		int gap;
		for (n = 0; n < 200; n++) begin
			gap = $urandom_range(0, 6);
			repeat (gap) @(posedge clk);
			r = $urandom();
			runAndCheck(port, aluPkg::aluOp'(r[3:0]), randWord(), randWord(), 0);
		end
	endtask

	task automatic mixedTraffic();
		fork
			randomStream(0);
			randomStream(1);
		join
	endtask

	task automatic resetMidTransaction();
		@(posedge clk);
		cmdOp0 <= aluPkg::ADD;
		cmdA0 <= 16'h00FF;
		cmdReq0 <= 1'b1;
		cmdOp1 <= aluPkg::LSH;
		cmdA1 <= 16'h8001;
		cmdReq1 <= 1'b1;
		// Core is busy with port 0 by now
		repeat (3) @(posedge clk);
		applyReset();
		@(negedge clk);
		checkFlag(cmdAck0, 1'b0, "cmdAck0 after reset");
		checkFlag(cmdAck1, 1'b0, "cmdAck1 after reset");
		checkState(i_aluTop.i_cmdPort0.state, aluPkg::IDLE, "port 0 FSM after reset");
		checkState(i_aluTop.i_cmdPort1.state, aluPkg::IDLE, "port 1 FSM after reset");
		runAndCheck(0, aluPkg::OR, 16'h0F00, 16'h00F0, 0);
		runAndCheck(1, aluPkg::RSH, 16'h0003, 16'h0000, 0);
	endtask

	initial begin
		void'($urandom(32'h34d9));
		clk = 1'b0;
		rst = 1'b1;
		cmdReq0 = 1'b0;
		cmdOp0 = aluPkg::LD;
		cmdA0 = '0;
		cmdB0 = '0;
		cmdReq1 = 1'b0;
		cmdOp1 = aluPkg::LD;
		cmdA1 = '0;
		cmdB1 = '0;
		applyReset();
		sweepOpcodes();
		contendBothPorts();
		stallPortZero();
		mixedTraffic();
		resetMidTransaction();
		$display("Simulation passed");
		$finish;
	end

	// Watchdog sized from the transaction count
	initial begin
		#(numTransactions * cyclesPerTransaction * clkPeriod);
		$display("Timeout: the client handshakes did not finish in time");
		$display("Simulation failed");
		$fatal(1);
	end

endmodule

/* list.f */
aluPkg.sv
aluCore.sv
aluArbiter.sv
cmdPort.sv
aluTop.sv
aluArbiter_asserts.sv
aluTopTb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module aluTopTb -f list.f -o aluSim > build.log 2>&1 \
	|| { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/aluSim > sim.log 2>&1
cat sim.log
grep -q "Simulation passed" sim.log && exit 0 || exit 1
